//--- Makefile
# Verilator build and run for the instruction cache testbench.

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass message.
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- source/icache.sv
`default_nettype none

module icache (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rvga_pkg::fetch_req_t fetch_req,
    output rvga_pkg::fetch_rsp_t      fetch_rsp,
    output rvga_pkg::mem_req_t        mem_req,
    input  wire rvga_pkg::mem_rsp_t   mem_rsp
);

    logic               hit;
    rvga_pkg::way_sel_t hit_way;
    rvga_pkg::way_sel_t valid_ways;
    rvga_pkg::way_sel_t victim;
    rvga_pkg::way_sel_t way_load;
    rvga_pkg::way_sel_t lru_way;
    rvga_pkg::rvga_word rdata;
    logic               fill_word_en;
    logic [1:0]         fill_count;
    logic               lru_touch;

    // ##################################################
    // fsm
    // ##################################################
    icache_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_rsp    (fetch_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim       (victim),
        .rdata        (rdata),
        .fill_word_en (fill_word_en),
        .fill_count   (fill_count),
        .way_load     (way_load),
        .lru_touch    (lru_touch),
        .lru_way      (lru_way)
    );

    // ##################################################
    // arrays and replacement
    // ##################################################
    icache_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (fetch_req.addr),
        .mem_rdata    (mem_rsp.rdata),
        .fill_word_en (fill_word_en),
        .fill_count   (fill_count),
        .way_load     (way_load),
        .hit          (hit),
        .hit_way      (hit_way),
        .valid_ways   (valid_ways),
        .rdata        (rdata)
    );

    icache_lru u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (fetch_req.addr.fields.index),
        .touch      (lru_touch),
        .touch_way  (lru_way),
        .valid_ways (valid_ways),
        .victim     (victim)
    );

endmodule

`default_nettype wire

//--- source/icache_array.sv
`default_nettype none

module icache_array #(
    parameter int width  = 1,
    parameter int height = rvga_pkg::lines_per_way
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            load,
    input  wire [rvga_pkg::index_bits-1:0] index,
    input  wire [width-1:0]                data_in,
    output logic [width-1:0]               data_out
);

    logic [width-1:0] mem [height];

    // ##################################################
    // write port
    // ##################################################
    // cleared on reset so the valid copies start out empty.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < height; i++) begin
                mem[i] <= '0;
            end
        end else if (load) begin
            mem[index] <= data_in;
        end
    end

    // ##################################################
    // read port
    // ##################################################
    assign data_out = mem[index];  // same-cycle read.

endmodule

`default_nettype wire

//--- source/icache_control.sv
`default_nettype none

module icache_control (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rvga_pkg::fetch_req_t fetch_req,
    output rvga_pkg::fetch_rsp_t      fetch_rsp,
    output rvga_pkg::mem_req_t        mem_req,
    input  wire rvga_pkg::mem_rsp_t   mem_rsp,
    input  wire                       hit,
    input  wire rvga_pkg::way_sel_t   hit_way,
    input  wire rvga_pkg::way_sel_t   victim,
    input  wire rvga_pkg::rvga_word   rdata,
    output logic                      fill_word_en,
    output logic [1:0]                fill_count,
    output rvga_pkg::way_sel_t        way_load,
    output logic                      lru_touch,
    output rvga_pkg::way_sel_t        lru_way
);

    typedef enum logic [2:0] {
        s_idle,
        s_request,      // one-cycle read strobe.
        s_wait_rsp,     // words 0..2.
        s_write_line,   // last word, line goes into the victim way.
        s_respond       // repeated lookup after the fill.
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    rvga_pkg::way_sel_t     victim_q;
    rvga_pkg::icache_addr_u fill_addr;
    logic                   lookup;
    logic                   respond;
    logic                   rsp_valid;
    rvga_pkg::rvga_word     rsp_rdata;

    // the cycle after a response the request is still held, so skip it.
    assign lookup  = (state == s_idle) && fetch_req.valid && !rsp_valid;
    assign respond = hit && (lookup || (state == s_respond));

    assign fill_word_en = mem_rsp.valid && ((state == s_wait_rsp) || (state == s_write_line));
    assign way_load     = (mem_rsp.valid && (state == s_write_line)) ? victim_q : '0;
    assign lru_touch    = respond;
    assign lru_way      = hit_way;

    // ##################################################
    // state machine
    // ##################################################
    always_comb begin
        state_nxt = state;
        case (state)
            s_idle:       if (lookup && !hit) state_nxt = s_request;
            s_request:    state_nxt = (fill_count == 2'd3) ? s_write_line : s_wait_rsp;
            s_wait_rsp:   if (mem_rsp.valid) state_nxt = s_request;
            s_write_line: if (mem_rsp.valid) state_nxt = s_respond;
            s_respond:    state_nxt = s_idle;
            default:      state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= s_idle;
            victim_q   <= '0;
            fill_count <= '0;
            rsp_valid  <= 1'b0;
        end else begin
            state     <= state_nxt;
            rsp_valid <= respond;
            if (lookup && !hit) begin
                victim_q <= victim;          // held through the whole fill.
            end
            if (fill_word_en) begin
                fill_count <= fill_count + 2'd1;  // wraps to 0 after the last word.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respond) begin
            rsp_rdata <= rdata;
        end
    end

    // ##################################################
    // outputs
    // ##################################################
    always_comb begin
        fill_addr                 = fetch_req.addr;
        fill_addr.fields.word_off = fill_count;
        fill_addr.fields.byte_off = '0;
        mem_req.read              = (state == s_request);
        mem_req.addr              = fill_addr.raw;
    end

    assign fetch_rsp.valid = rsp_valid;
    assign fetch_rsp.rdata = rsp_rdata;

endmodule

`default_nettype wire

//--- source/icache_datapath.sv
`default_nettype none

module icache_datapath (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rvga_pkg::icache_addr_u addr,
    input  wire rvga_pkg::rvga_word     mem_rdata,
    input  wire                         fill_word_en,
    input  wire [1:0]                   fill_count,
    input  wire rvga_pkg::way_sel_t     way_load,
    output logic                        hit,
    output rvga_pkg::way_sel_t          hit_way,
    output rvga_pkg::way_sel_t          valid_ways,
    output rvga_pkg::rvga_word          rdata
);

    localparam int line_bits = $bits(rvga_pkg::icache_line_t);

    logic                          valid_out [rvga_pkg::num_ways];
    logic [rvga_pkg::tag_bits-1:0] tag_out   [rvga_pkg::num_ways];
    rvga_pkg::icache_line_t        line_out  [rvga_pkg::num_ways];

    rvga_pkg::icache_line_t        fill_buf;
    rvga_pkg::icache_line_t        fill_line;

    // ##################################################
    // way storage
    // ##################################################
    for (genvar g = 0; g < rvga_pkg::num_ways; g++) begin : g_way
        icache_array #(
            .width  (1),
            .height (rvga_pkg::lines_per_way)
        ) u_valid (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (way_load[g]),
            .index    (addr.fields.index),
            .data_in  (1'b1),
            .data_out (valid_out[g])
        );

        icache_array #(
            .width  (rvga_pkg::tag_bits),
            .height (rvga_pkg::lines_per_way)
        ) u_tag (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (way_load[g]),
            .index    (addr.fields.index),
            .data_in  (addr.fields.tag),
            .data_out (tag_out[g])
        );

        icache_array #(
            .width  (line_bits),
            .height (rvga_pkg::lines_per_way)
        ) u_line (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (way_load[g]),
            .index    (addr.fields.index),
            .data_in  (fill_line),
            .data_out (line_out[g])
        );
    end

    // ##################################################
    // lookup
    // ##################################################
    always_comb begin
        hit_way    = '0;
        valid_ways = '0;
        rdata      = '0;
        for (int w = 0; w < rvga_pkg::num_ways; w++) begin
            valid_ways[w] = valid_out[w];
            if (valid_out[w] && (tag_out[w] == addr.fields.tag)) begin
                hit_way[w] = 1'b1;
                rdata      = rdata | line_out[w][addr.fields.word_off];  // at most one way hits.
            end
        end
        hit = |hit_way;
    end

    // ##################################################
    // line fill buffer
    // ##################################################
    // the arriving word is merged in, so the last word can be
    // written to the way in the same cycle it shows up.
    always_comb begin
        fill_line = fill_buf;
        if (fill_word_en) begin
            fill_line[fill_count] = mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_word_en) begin
            fill_buf <= fill_line;
        end
    end

endmodule

`default_nettype wire

//--- source/icache_lru.sv
`default_nettype none

module icache_lru (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [rvga_pkg::index_bits-1:0] index,
    input  wire                            touch,
    input  wire rvga_pkg::way_sel_t        touch_way,
    input  wire rvga_pkg::way_sel_t        valid_ways,
    output rvga_pkg::way_sel_t             victim
);

    // bit 0 picks the pair, bit 1 ways 0/1, bit 2 ways 2/3.
    logic [2:0] tree [rvga_pkg::lines_per_way];
    logic [2:0] cur_bits;
    logic [2:0] nxt_bits;

    assign cur_bits = tree[index];

    // ##################################################
    // victim choice
    // ##################################################
    always_comb begin
        if (!valid_ways[0]) begin
            victim = 4'b0001;                       // fill empty ways first.
        end else if (!valid_ways[1]) begin
            victim = 4'b0010;
        end else if (!valid_ways[2]) begin
            victim = 4'b0100;
        end else if (!valid_ways[3]) begin
            victim = 4'b1000;
        end else if (!cur_bits[0]) begin
            victim = cur_bits[1] ? 4'b0010 : 4'b0001;
        end else begin
            victim = cur_bits[2] ? 4'b1000 : 4'b0100;
        end
    end

    // ##################################################
    // update on touch
    // ##################################################
    // the path to the touched way is turned to point away from it.
    always_comb begin
        nxt_bits = cur_bits;
        if (touch_way[0] || touch_way[1]) begin
            nxt_bits[0] = 1'b1;
            nxt_bits[1] = touch_way[0];
        end else begin
            nxt_bits[0] = 1'b0;
            nxt_bits[2] = touch_way[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rvga_pkg::lines_per_way; i++) begin
                tree[i] <= '0;
            end
        end else if (touch) begin
            tree[index] <= nxt_bits;
        end
    end

endmodule

`default_nettype wire

//--- source/rvga_pkg.sv
`default_nettype none

package rvga_pkg;

    // ##################################################
    // cache geometry
    // ##################################################
    localparam int num_ways      = 4;
    localparam int lines_per_way = 16;
    localparam int line_words    = 4;
    localparam int index_bits    = 4;
    localparam int offset_bits   = 4;
    localparam int tag_bits      = 24;

    typedef logic [31:0] rvga_word;

    // fetch address as seen by the lookup.
    typedef struct packed {
        logic [tag_bits-1:0]      tag;
        logic [index_bits-1:0]    index;
        logic [offset_bits-3:0]   word_off;
        logic [1:0]               byte_off;   // ignored, fetches are aligned.
    } icache_addr_t;

    // raw word for the memory port, fields for the tag/index compare.
    typedef union packed {
        rvga_word                 raw;
        icache_addr_t             fields;
    } icache_addr_u;

    typedef rvga_word [line_words-1:0] icache_line_t;

    typedef logic [num_ways-1:0] way_sel_t;  // one-hot.

    // ##################################################
    // port bundles
    // ##################################################
    typedef struct packed {
        logic                     valid;
        icache_addr_u             addr;
    } fetch_req_t;

    typedef struct packed {
        logic                     valid;
        rvga_word                 rdata;
    } fetch_rsp_t;

    typedef struct packed {
        logic                     read;
        rvga_word                 addr;
    } mem_req_t;

    typedef struct packed {
        logic                     valid;
        rvga_word                 rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- tb/icache_checker.sv
`default_nettype none

module icache_checker (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rvga_pkg::fetch_req_t fetch_req,
    input  wire rvga_pkg::fetch_rsp_t fetch_rsp,
    input  wire rvga_pkg::mem_req_t   mem_req,
    input  wire rvga_pkg::mem_rsp_t   mem_rsp,
    input  wire                       done,
    output int                        error_count
);

    localparam int chk_data    = 0;
    localparam int chk_fill    = 1;
    localparam int chk_latency = 2;
    localparam int chk_replace = 3;
    localparam int chk_reset   = 4;
    localparam int num_checks  = 5;

    string check_names [num_checks] = '{"data", "fill_order", "hit_latency",
                                        "replacement", "reset"};
    int    errs [num_checks];

    // reference copy of tags, valid bits and tree bits.
    logic [rvga_pkg::tag_bits-1:0] tags   [rvga_pkg::lines_per_way][rvga_pkg::num_ways];
    bit                            valids [rvga_pkg::lines_per_way][rvga_pkg::num_ways];
    bit [2:0]                      tree   [rvga_pkg::lines_per_way];
    bit                            seen_line [bit [27:0]];

    rvga_pkg::icache_addr_u req_addr;
    bit                     pending;
    bit                     predict_hit;
    bit                     summary_done;
    int                     way;
    int                     cyc;
    int                     reads;
    int                     rsps;
    int                     last_rsp_cyc;

    function automatic rvga_pkg::rvga_word expected_word(input rvga_pkg::rvga_word addr);
        rvga_pkg::rvga_word x;
        x = addr ^ 32'h5a3c_96e1;
        return {x[26:0], x[31:27]};  // rotate left by 5.
    endfunction

    function automatic int find_way(input logic [3:0] idx, input logic [23:0] tag);
        for (int w = 0; w < rvga_pkg::num_ways; w++) begin
            if (valids[idx][w] && (tags[idx][w] == tag)) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic int pick_victim(input logic [3:0] idx);
        for (int w = 0; w < rvga_pkg::num_ways; w++) begin
            if (!valids[idx][w]) begin
                return w;  // empty ways go first.
            end
        end
        if (!tree[idx][0]) begin
            return tree[idx][1] ? 1 : 0;
        end
        return tree[idx][2] ? 3 : 2;
    endfunction

    task automatic touch_way(input logic [3:0] idx, input int w);
        tree[idx][0] = (w < 2);  // pair bit points at the other pair.
        if (w < 2) begin
            tree[idx][1] = (w == 0);
        end else begin
            tree[idx][2] = (w == 2);
        end
    endtask

    task automatic mismatch(input int chk, input logic [31:0] expected,
                            input logic [31:0] actual);
        errs[chk]++;
        $display("** Error: %s: expected %h, actual %h, time %0t",
                 check_names[chk], expected, actual, $time);
    endtask

    task automatic fault(input int chk, input string what);
        errs[chk]++;
        $display("%s check failed: %s, time %0t", check_names[chk], what, $time);
    endtask

    // ##################################################
    // per-fetch tracking
    // ##################################################
    task automatic start_fetch();
        req_addr    = fetch_req.addr;
        way         = find_way(req_addr.fields.index, req_addr.fields.tag);
        predict_hit = (way >= 0);
        if (!predict_hit) begin
            way = pick_victim(req_addr.fields.index);
        end
        pending      = 1'b1;
        cyc          = 0;
        reads        = 0;
        rsps         = 0;
        last_rsp_cyc = 0;
    endtask

    task automatic check_read();
        rvga_pkg::rvga_word expected;
        expected = {req_addr.raw[31:4], 2'(reads), 2'b00};
        if (predict_hit) begin
            fault(chk_fill, "memory read on a predicted hit");
        end else if (reads >= rvga_pkg::line_words) begin
            fault(chk_fill, "more than four memory reads for one miss");
        end else if (mem_req.addr !== expected) begin
            mismatch(chk_fill, expected, mem_req.addr);
        end
        reads++;
    endtask

    task automatic finish_fetch();
        rvga_pkg::rvga_word expected;
        logic [27:0]        line;
        logic [3:0]         idx;
        expected = expected_word({req_addr.raw[31:2], 2'b00});
        line     = req_addr.raw[31:4];
        idx      = req_addr.fields.index;
        if (fetch_rsp.rdata !== expected) begin
            mismatch(chk_data, expected, fetch_rsp.rdata);
        end
        if (reads != (predict_hit ? 0 : 4)) begin
            mismatch(chk_replace, predict_hit ? 0 : 4, reads);
        end
        if (predict_hit && (cyc != 1)) begin
            mismatch(chk_latency, 1, cyc);
        end else if (!predict_hit && (rsps == 4) && (cyc - last_rsp_cyc != 2)) begin
            mismatch(chk_latency, 2, cyc - last_rsp_cyc);
        end
        if (!seen_line.exists(line)) begin
            if (reads != 4) begin
                mismatch(chk_reset, 4, reads);  // first touch of a line.
            end
            seen_line[line] = 1'b1;
        end
        if (!predict_hit) begin
            tags[idx][way]   = req_addr.fields.tag;
            valids[idx][way] = 1'b1;
        end
        touch_way(idx, way);
        pending = 1'b0;
    endtask

    // ##################################################
    // sampling
    // ##################################################
    always @(negedge clk) begin
        if (!rst_n) begin
            if (fetch_rsp.valid !== 1'b0) begin
                fault(chk_reset, "fetch response valid not low during reset");
            end
            if (mem_req.read !== 1'b0) begin
                fault(chk_reset, "memory read not low during reset");
            end
            pending = 1'b0;
            for (int i = 0; i < rvga_pkg::lines_per_way; i++) begin
                tree[i] = '0;
                for (int w = 0; w < rvga_pkg::num_ways; w++) begin
                    valids[i][w] = 1'b0;
                end
            end
        end else begin
            if (pending) begin
                cyc++;
                if (mem_req.read) begin
                    check_read();
                end
                if (mem_rsp.valid) begin
                    rsps++;
                    last_rsp_cyc = cyc;
                end
            end else if (mem_req.read) begin
                fault(chk_fill, "memory read with no fetch outstanding");
            end
            if (fetch_rsp.valid) begin
                if (pending) begin
                    finish_fetch();
                end else begin
                    fault(chk_latency, "fetch response with no fetch outstanding");
                end
            end else if (!pending && fetch_req.valid) begin
                start_fetch();
            end
        end
        error_count = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
        if (done && !summary_done) begin
            $display(
                "errors: data %0d, fill_order %0d, hit_latency %0d, replacement %0d, reset %0d",
                errs[chk_data], errs[chk_fill], errs[chk_latency],
                errs[chk_replace], errs[chk_reset]);
            summary_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_icache.sv
`default_nettype none

module tb_icache;

    localparam int num_fetches      = 600;
    localparam int cycles_per_fetch = 30;
    localparam int num_lines        = 12;

    logic                 clk;
    logic                 rst_n;
    rvga_pkg::fetch_req_t fetch_req;
    rvga_pkg::fetch_rsp_t fetch_rsp;
    rvga_pkg::mem_req_t   mem_req;
    rvga_pkg::mem_rsp_t   mem_rsp;
    logic                 done;
    int                   error_count;
    int                   seed = 2192;

    icache u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    icache_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_rsp   (fetch_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .done        (done),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory content, a scrambled copy of the address.
    function automatic rvga_pkg::rvga_word mem_word(input rvga_pkg::rvga_word addr);
        rvga_pkg::rvga_word x;
        x = addr ^ 32'h5a3c_96e1;
        return {x[26:0], x[31:27]};
    endfunction

    // five lines on index 3 fight over four ways, the rest fit.
    function automatic rvga_pkg::rvga_word line_base(input int p);
        logic [3:0] idx;
        if (p < 5) begin
            idx = 4'h3;
        end else if (p < 8) begin
            idx = 4'h9;
        end else if (p < 10) begin
            idx = 4'hc;
        end else begin
            idx = 4'h0;
        end
        return {8'h01, 4'(p), 12'h0a5, idx, 4'h0};
    endfunction

    // ##################################################
    // memory model
    // ##################################################
    initial begin : memory_model
        rvga_pkg::rvga_word addr;
        int                 latency;
        forever begin
            @(negedge clk);
            if (mem_req.read) begin
                addr    = mem_req.addr;
                latency = 1 + ($random(seed) & 3);  // 1 to 4 cycles.
                repeat (latency) @(posedge clk);
                mem_rsp.valid <= 1'b1;
                mem_rsp.rdata <= mem_word(addr);
                @(posedge clk);
                mem_rsp.valid <= 1'b0;
            end
        end
    end

    // ##################################################
    // fetch stimulus
    // ##################################################
    initial begin : stimulus
        int                 p;
        rvga_pkg::rvga_word addr;
        rst_n     = 1'b0;
        fetch_req = '0;
        mem_rsp   = '0;
        done      = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < num_fetches; n++) begin
            @(posedge clk);
            p    = ($random(seed) & 32'h7fff_ffff) % num_lines;
            addr = line_base(p) | ($random(seed) & 32'hf);  // word and ignored byte bits.
            fetch_req.valid    <= 1'b1;
            fetch_req.addr.raw <= addr;
            @(negedge clk);
            while (!fetch_rsp.valid) begin
                @(negedge clk);
            end
            if (($random(seed) & 3) == 0) begin
                @(posedge clk);
                fetch_req.valid <= 1'b0;  // idle cycle between fetches.
            end
        end
        @(posedge clk);
        fetch_req.valid <= 1'b0;
        done            <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (num_fetches * cycles_per_fetch) @(posedge clk);
        $display("timeout: %0d fetches did not complete within %0d cycles",
                 num_fetches, num_fetches * cycles_per_fetch);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/rvga_pkg.sv
source/icache_array.sv
source/icache_lru.sv
source/icache_datapath.sv
source/icache_control.sv
source/icache.sv
tb/icache_checker.sv
tb/tb_icache.sv
